/* verilog/twiddle_table.svh */
// Q8 twiddle factors of the 32-point FFT, W^k = cos - j sin of 2*pi*k/32
// Included inside fft_pkg after the sample type is declared

`ifndef TWIDDLE_TABLE_SVH
`define TWIDDLE_TABLE_SVH

// round(256 * cos(2*pi*k/32)), k = 0 .. 15
localparam sample_t TW_COS [FFT_N/2] = '{
        16'sd256,  16'sd251,  16'sd237,  16'sd213,
        16'sd181,  16'sd142,  16'sd98,   16'sd50,
        16'sd0,   -16'sd50,  -16'sd98,  -16'sd142,
       -16'sd181, -16'sd213, -16'sd237, -16'sd251
};

// round(256 * sin(2*pi*k/32)), k = 0 .. 15
localparam sample_t TW_SIN [FFT_N/2] = '{
        16'sd0,    16'sd50,   16'sd98,   16'sd142,
        16'sd181,  16'sd213,  16'sd237,  16'sd251,
        16'sd256,  16'sd251,  16'sd237,  16'sd213,
        16'sd181,  16'sd142,  16'sd98,   16'sd50
};

`endif

/* verilog/bus_pkg.sv */
// Bus side definitions for the FFT accelerator
// Request fields, address map and the decoded command set

package bus_pkg;

        // One bus transfer as seen at the accelerator boundary
        typedef struct packed {
                logic        en;
                logic        we;
                logic [7:0]  addr;
                logic [31:0] data;
        } bus_req_t;

        // Control register, bit 0 starts a transform
        // Lower addresses select a sample by addr[4:0]
        localparam logic [7:0] ADDR_CTRL = 8'h80;

        typedef enum logic [1:0] {
                CMD_NONE,
                CMD_SAMPLE,
                CMD_START
        } bus_cmd_e;

endpackage

/* verilog/fft_pkg.sv */
// Data types and constants of the 32-point fixed-point FFT
// Shared by the buffer, the butterfly and the sequencer

package fft_pkg;

        localparam int FFT_N     = 32;
        localparam int FFT_LOG2N = 5;
        localparam int FRAC_BITS = 8;

        typedef logic signed [15:0] sample_t;

        typedef struct packed {
                sample_t re;
                sample_t im;
        } cplx_t;

        typedef logic [FFT_LOG2N-1:0] idx_t;
        typedef logic [FFT_LOG2N-2:0] tw_idx_t;

        // Whole buffer, entry k at bits [32k+31:32k]
        typedef cplx_t [FFT_N-1:0] frame_t;

        typedef struct packed {
                logic    valid;
                idx_t    idx_a;
                idx_t    idx_b;
                tw_idx_t tw;
        } bfly_req_t;

        typedef struct packed {
                logic  valid;
                idx_t  idx_a;
                idx_t  idx_b;
                cplx_t res_a;
                cplx_t res_b;
        } bfly_res_t;

        typedef enum logic [1:0] {
                S_IDLE,
                S_RUN,
                S_DRAIN,
                S_DONE
        } fft_state_e;

        `include "twiddle_table.svh"

endpackage

/* verilog/sample_ram.sv */
// In-place complex buffer of the FFT
// Bus samples land in bit-reversed order, butterflies read two words and write two back

`timescale 1ns/1ps

module sample_ram
        import fft_pkg::*;
(
        input  logic      clk,
        input  logic      arst_n_i,

        input  logic      smp_we_i,
        input  idx_t      smp_idx_i,
        input  sample_t   smp_val_i,

        input  bfly_req_t req_i,
        input  bfly_res_t res_i,

        output cplx_t     op_a_o,
        output cplx_t     op_b_o,
        output frame_t    frame_o
);

        frame_t mem;
        idx_t   smp_idx_rev;

        // Decimation in time wants the input in bit-reversed order
        always_comb begin
                for (int i = 0; i < FFT_LOG2N; i++) begin
                        smp_idx_rev[i] = smp_idx_i[FFT_LOG2N-1-i];
                end
        end

        //////////////////////////////
        // Storage
        //////////////////////////////

        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        mem <= '0;
                end else if (res_i.valid) begin
                        mem[res_i.idx_a] <= res_i.res_a;
                        mem[res_i.idx_b] <= res_i.res_b;
                end else if (smp_we_i) begin
                        // Real input only
                        mem[smp_idx_rev] <= '{re: smp_val_i, im: '0};
                end
        end

        // Operands for the butterfly issued this cycle
        assign op_a_o = mem[req_i.idx_a];
        assign op_b_o = mem[req_i.idx_b];

        assign frame_o = mem;

endmodule

/* verilog/fft_butterfly.sv */
// Radix-2 DIT butterfly with two register stages and no stall
// Products are registered first, sum and difference land two cycles after the request

`timescale 1ns/1ps

module fft_butterfly
        import fft_pkg::*;
#(
        parameter bit SCALE_STAGES = 1'b1
) (
        input  logic      clk,
        input  logic      arst_n_i,
        input  bfly_req_t req_i,
        input  cplx_t     op_a_i,
        input  cplx_t     op_b_i,
        output bfly_res_t res_o
);

        typedef logic signed [31:0] prod_t;

        sample_t            tw_cos;
        sample_t            tw_sin;
        logic               v1_q, v2_q;
        idx_t               ia1_q, ib1_q, ia2_q, ib2_q;
        cplx_t              a1_q;
        prod_t              p_rc_q, p_is_q, p_ic_q, p_rs_q;
        logic signed [32:0] sum_re, sum_im;
        sample_t            t_re, t_im;
        logic signed [16:0] up_re, up_im, lo_re, lo_im;
        cplx_t              ra_q, rb_q;

        // Optional halving keeps the growth of each stage in range
        function automatic sample_t fit(input logic signed [16:0] v);
                if (SCALE_STAGES)
                        return sample_t'(v >>> 1);
                else
                        return sample_t'(v);
        endfunction

        assign tw_cos = TW_COS[req_i.tw];
        assign tw_sin = TW_SIN[req_i.tw];

        // t = b * (cos - j sin)
        always_comb begin
                sum_re = p_rc_q + p_is_q;
                sum_im = p_ic_q - p_rs_q;
                t_re   = sample_t'(sum_re >>> FRAC_BITS);
                t_im   = sample_t'(sum_im >>> FRAC_BITS);
                up_re  = a1_q.re + t_re;
                up_im  = a1_q.im + t_im;
                lo_re  = a1_q.re - t_re;
                lo_im  = a1_q.im - t_im;
        end

        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        v1_q <= 1'b0;
                        v2_q <= 1'b0;
                end else begin
                        v1_q <= req_i.valid;
                        v2_q <= v1_q;
                end
        end

        always_ff @(posedge clk) begin
                // Stage 1
                p_rc_q <= op_b_i.re * tw_cos;
                p_is_q <= op_b_i.im * tw_sin;
                p_ic_q <= op_b_i.im * tw_cos;
                p_rs_q <= op_b_i.re * tw_sin;
                a1_q   <= op_a_i;
                ia1_q  <= req_i.idx_a;
                ib1_q  <= req_i.idx_b;
                // Stage 2
                ra_q   <= '{re: fit(up_re), im: fit(up_im)};
                rb_q   <= '{re: fit(lo_re), im: fit(lo_im)};
                ia2_q  <= ia1_q;
                ib2_q  <= ib1_q;
        end

        assign res_o = '{valid: v2_q, idx_a: ia2_q, idx_b: ib2_q, res_a: ra_q, res_b: rb_q};

endmodule

/* verilog/fft_control.sv */
// Bus command decoder and FFT sequencer
// Each stage issues 16 butterflies back to back, then waits two cycles for the writes

`timescale 1ns/1ps

module fft_control
        import bus_pkg::*, fft_pkg::*;
(
        input  logic      clk,
        input  logic      arst_n_i,
        input  bus_req_t  bus_i,

        output logic      smp_we_o,
        output idx_t      smp_idx_o,
        output sample_t   smp_val_o,
        output bfly_req_t req_o,
        output logic      done_o,
        output logic      busy_o
);

        typedef logic [FFT_LOG2N-2:0] bfly_cnt_t;

        localparam logic [2:0] LAST_STAGE = 3'(FFT_LOG2N - 1);
        localparam bfly_cnt_t  LAST_BFLY  = bfly_cnt_t'(FFT_N / 2 - 1);

        bus_cmd_e   cmd, cmd_ok;
        fft_state_e state_q, state_d;
        logic [2:0] stage_q;
        bfly_cnt_t  bfly_q;
        logic       drain_q;
        bfly_cnt_t  span_mask, pos;
        idx_t       idx_a, idx_b;

        //////////////////////////////
        // Command decode
        //////////////////////////////

        always_comb begin
                cmd = CMD_NONE;
                if (bus_i.en && bus_i.we) begin
                        if (bus_i.addr < ADDR_CTRL)
                                cmd = CMD_SAMPLE;
                        else if (bus_i.addr == ADDR_CTRL && bus_i.data[0])
                                cmd = CMD_START;
                end
        end

        // Bus is locked out during a transform
        assign cmd_ok = busy_o ? CMD_NONE : cmd;

        assign smp_we_o  = (cmd_ok == CMD_SAMPLE);
        assign smp_idx_o = bus_i.addr[FFT_LOG2N-1:0];
        assign smp_val_o = sample_t'(bus_i.data[15:0]);

        //////////////////////////////
        // Sequencer
        //////////////////////////////

        always_comb begin
                state_d = state_q;
                case (state_q)
                        S_IDLE, S_DONE:
                                state_d = (cmd_ok == CMD_START) ? S_RUN : S_IDLE;
                        S_RUN:
                                if (bfly_q == LAST_BFLY)
                                        state_d = S_DRAIN;
                        S_DRAIN:
                                if (drain_q)
                                        state_d = (stage_q == LAST_STAGE) ? S_DONE : S_RUN;
                        default:
                                state_d = S_IDLE;
                endcase
        end

        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        state_q <= S_IDLE;
                        stage_q <= '0;
                        bfly_q  <= '0;
                        drain_q <= 1'b0;
                end else begin
                        state_q <= state_d;
                        case (state_q)
                                // Counter wraps to zero on the last butterfly
                                S_RUN:
                                        bfly_q <= bfly_q + 1'b1;
                                S_DRAIN: begin
                                        drain_q <= ~drain_q;
                                        if (drain_q)
                                                stage_q <= stage_q + 1'b1;
                                end
                                default: begin
                                        stage_q <= '0;
                                        bfly_q  <= '0;
                                        drain_q <= 1'b0;
                                end
                        endcase
                end
        end

        assign busy_o = (state_q == S_RUN) || (state_q == S_DRAIN);
        assign done_o = (state_q == S_DONE);

        // Pair j and j + m, m = 2^stage, twiddle (j mod m) * 16 / m
        always_comb begin
                span_mask = (bfly_cnt_t'(1) << stage_q) - bfly_cnt_t'(1);
                pos       = bfly_q & span_mask;
                idx_a     = ({1'b0, bfly_q >> stage_q} << (stage_q + 3'd1)) | {1'b0, pos};
                idx_b     = idx_a | (idx_t'(1) << stage_q);
        end

        assign req_o = '{
                valid: (state_q == S_RUN),
                idx_a: idx_a,
                idx_b: idx_b,
                tw:    tw_idx_t'(pos << (LAST_STAGE - stage_q))
        };

endmodule

/* verilog/fft_top.sv */
// Top level of the iterative 32-point FFT accelerator
// Samples and the start command arrive on a strobe bus, done_o marks a valid result_o

`timescale 1ns/1ps

module fft_top
        import bus_pkg::*, fft_pkg::*;
#(
        parameter bit SCALE_STAGES = 1'b1
) (
        input  logic        clk,
        input  logic        arst_n_i,

        input  logic        en_i,
        input  logic        we_i,
        input  logic [7:0]  addr_i,
        input  logic [31:0] data_i,

        output frame_t      result_o,
        output logic        done_o,
        output logic        busy_o
);

        bus_req_t  bus_req;
        logic      smp_we;
        idx_t      smp_idx;
        sample_t   smp_val;
        bfly_req_t bfly_req;
        bfly_res_t bfly_res;
        cplx_t     op_a, op_b;

        assign bus_req = '{en: en_i, we: we_i, addr: addr_i, data: data_i};

        fft_control i_ctrl (
                .clk       (clk),
                .arst_n_i  (arst_n_i),
                .bus_i     (bus_req),
                .smp_we_o  (smp_we),
                .smp_idx_o (smp_idx),
                .smp_val_o (smp_val),
                .req_o     (bfly_req),
                .done_o    (done_o),
                .busy_o    (busy_o)
        );

        sample_ram i_ram (
                .clk       (clk),
                .arst_n_i  (arst_n_i),
                .smp_we_i  (smp_we),
                .smp_idx_i (smp_idx),
                .smp_val_i (smp_val),
                .req_i     (bfly_req),
                .res_i     (bfly_res),
                .op_a_o    (op_a),
                .op_b_o    (op_b),
                .frame_o   (result_o)
        );

        fft_butterfly #(
                .SCALE_STAGES (SCALE_STAGES)
        ) i_bfly (
                .clk       (clk),
                .arst_n_i  (arst_n_i),
                .req_i     (bfly_req),
                .op_a_i    (op_a),
                .op_b_i    (op_b),
                .res_o     (bfly_res)
        );

endmodule

/* sim/tb_fft_top.sv */
// Testbench of the iterative 32-point FFT accelerator
// Loads LFSR frames over the bus, starts transforms and checks result_o against a model

`timescale 1ns/1ps

module tb_fft_top
        import bus_pkg::*, fft_pkg::*;
();

        localparam int          CLK_PERIOD    = 20;
        localparam int          RESET_CYCLES  = 10;
        localparam bit          SCALE_STAGES  = 1'b1;
        localparam int          RAND_FRAMES   = 8;
        localparam int          FRAME_CYCLES  = 150;
        localparam int          TOTAL_FRAMES  = 3 + RAND_FRAMES;
        localparam int          WATCHDOG_NS   = (TOTAL_FRAMES + 1) * FRAME_CYCLES * CLK_PERIOD;
        localparam logic [15:0] SEED          = 16'd64882;

        logic        clk;
        logic        arst_n_i;
        logic        en_i;
        logic        we_i;
        logic [7:0]  addr_i;
        logic [31:0] data_i;
        frame_t      result_o;
        logic        done_o;
        logic        busy_o;

        logic [15:0] lfsr;
        logic [31:0] rnd;
        sample_t     in_smp [FFT_N];
        frame_t      exp_frame;
        cplx_t       zero_bin;
        cplx_t       impulse_bin;
        int          errors;
        int          checks;
        int          done_count;
        int          starts;
        logic        done_prev;

        fft_top #(
                .SCALE_STAGES (SCALE_STAGES)
        ) i_dut (
                .clk      (clk),
                .arst_n_i (arst_n_i),
                .en_i     (en_i),
                .we_i     (we_i),
                .addr_i   (addr_i),
                .data_i   (data_i),
                .result_o (result_o),
                .done_o   (done_o),
                .busy_o   (busy_o)
        );

        initial clk = 1'b0;
        always #(CLK_PERIOD / 2) clk = ~clk;

        //////////////////////////////
        // Random source and model
        //////////////////////////////

        // Fibonacci LFSR, taps 16 14 13 11
        function automatic logic [15:0] lfsr_next(input logic [15:0] s);
                logic fb;
                fb = s[15] ^ s[13] ^ s[12] ^ s[10];
                return {s[14:0], fb};
        endfunction

        task automatic take_bits(input int n, output logic [31:0] v);
                v = '0;
                repeat (n) begin
                        lfsr = lfsr_next(lfsr);
                        v    = {v[30:0], lfsr[0]};
                end
        endtask

        function automatic int bit_reverse(input int i);
                int r;
                r = 0;
                for (int b = 0; b < FFT_LOG2N; b++)
                        r = (r << 1) | ((i >> b) & 1);
                return r;
        endfunction

        function automatic sample_t halve_wrap(input int v);
                if (SCALE_STAGES)
                        return sample_t'(v >>> 1);
                return sample_t'(v);
        endfunction

        // Radix-2 DIT on bit-reversed input, Q8 twiddles W = cos - j sin
        task automatic compute_model();
                cplx_t   work [FFT_N];
                cplx_t   a, b;
                int      m, ja, jb, tw, pr, pi;
                sample_t t_re, t_im;
                for (int i = 0; i < FFT_N; i++) begin
                        work[bit_reverse(i)].re = in_smp[i];
                        work[bit_reverse(i)].im = '0;
                end
                for (int s = 0; s < FFT_LOG2N; s++) begin
                        m = 1 << s;
                        for (int g = 0; g < FFT_N; g += 2 * m) begin
                                for (int k = 0; k < m; k++) begin
                                        ja   = g + k;
                                        jb   = ja + m;
                                        tw   = k * (FFT_N / 2 / m);
                                        a    = work[ja];
                                        b    = work[jb];
                                        pr   = int'(b.re) * int'(TW_COS[tw])
                                               + int'(b.im) * int'(TW_SIN[tw]);
                                        pi   = int'(b.im) * int'(TW_COS[tw])
                                               - int'(b.re) * int'(TW_SIN[tw]);
                                        t_re = sample_t'(pr >>> FRAC_BITS);
                                        t_im = sample_t'(pi >>> FRAC_BITS);
                                        work[ja].re = halve_wrap(int'(a.re) + int'(t_re));
                                        work[ja].im = halve_wrap(int'(a.im) + int'(t_im));
                                        work[jb].re = halve_wrap(int'(a.re) - int'(t_re));
                                        work[jb].im = halve_wrap(int'(a.im) - int'(t_im));
                                end
                        end
                end
                for (int i = 0; i < FFT_N; i++)
                        exp_frame[i] = work[i];
        endtask

        //////////////////////////////
        // Compare tasks
        //////////////////////////////

        task automatic check_cplx(input int idx, input cplx_t got, input cplx_t exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("ERROR %0t: bin %0d got (%0d, %0d) expected (%0d, %0d)",
                                 $time, idx, got.re, got.im, exp.re, exp.im);
                end
        endtask

        task automatic check_flag(input string what, input logic got, input logic exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
                end
        endtask

        task automatic check_count(input string what, input int got, input int exp);
                checks++;
                if (got != exp) begin
                        errors++;
                        $display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, exp);
                end
        endtask

        // done_o must be a single cycle pulse with busy_o already low
        always @(negedge clk) begin
                if (arst_n_i) begin
                        if (done_o) begin
                                done_count++;
                                check_flag("busy_o during done_o", busy_o, 1'b0);
                        end
                        if (done_o && done_prev) begin
                                errors++;
                                $display("done_o stayed high for more than one cycle");
                        end
                        done_prev = done_o;
                end
        end

        //////////////////////////////
        // Bus tasks
        //////////////////////////////

        task automatic bus_cycle(input logic en, input logic we, input logic [7:0] addr,
                                 input logic [31:0] data);
                en_i   = en;
                we_i   = we;
                addr_i = addr;
                data_i = data;
                @(negedge clk);
                en_i   = 1'b0;
                we_i   = 1'b0;
        endtask

        task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
                bus_cycle(1'b1, 1'b1, addr, data);
        endtask

        task automatic fill_random();
                for (int i = 0; i < FFT_N; i++) begin
                        take_bits(16, rnd);
                        in_smp[i] = sample_t'(rnd[15:0]);
                end
        endtask

        // Upper data bits carry junk, only bits 15..0 are a sample
        task automatic load_frame();
                for (int i = 0; i < FFT_N; i++)
                        bus_write(8'(i), {16'hA5A5, in_smp[i]});
        endtask

        task automatic start_fft();
                check_count("done_o pulses before start", done_count, starts);
                starts++;
                bus_write(ADDR_CTRL, 32'h0000_0001);
                check_flag("busy_o after start", busy_o, 1'b1);
        endtask

        task automatic wait_done();
                int n;
                n = 0;
                while (!done_o && n < FRAME_CYCLES) begin
                        @(negedge clk);
                        n++;
                end
                if (!done_o) begin
                        errors++;
                        $display("done_o did not arrive within %0d cycles", FRAME_CYCLES);
                end
        endtask

        // Load, transform and compare, with optional junk writes while busy
        task automatic run_frame(input int busy_writes);
                load_frame();
                compute_model();
                start_fft();
                repeat (busy_writes) begin
                        take_bits(16, rnd);
                        check_flag("busy_o before dropped write", busy_o, 1'b1);
                        bus_write(8'(rnd[4:0]), {16'h0, rnd[15:0]});
                end
                wait_done();
                for (int i = 0; i < FFT_N; i++)
                        check_cplx(i, result_o[i], exp_frame[i]);
        endtask

        //////////////////////////////
        // Test sequence
        //////////////////////////////

        initial begin
                en_i       = 1'b0;
                we_i       = 1'b0;
                addr_i     = '0;
                data_i     = '0;
                arst_n_i   = 1'b0;
                lfsr       = SEED;
                errors     = 0;
                checks     = 0;
                done_count = 0;
                starts     = 0;
                done_prev  = 1'b0;
                zero_bin   = '0;
                impulse_bin.re = 16'sd8;
                impulse_bin.im = 16'sd0;

                repeat (RESET_CYCLES) @(negedge clk);
                arst_n_i = 1'b1;
                @(negedge clk);

                check_flag("busy_o after reset", busy_o, 1'b0);
                check_flag("done_o after reset", done_o, 1'b0);
                for (int i = 0; i < FFT_N; i++)
                        check_cplx(i, result_o[i], zero_bin);

                fill_random();
                run_frame(0);

                // 256 halved five times leaves 8 in every bin
                for (int i = 0; i < FFT_N; i++)
                        in_smp[i] = '0;
                in_smp[0] = 16'sd256;
                run_frame(0);
                for (int i = 0; i < FFT_N; i++) begin
                        check_cplx(i, exp_frame[i], impulse_bin);
                        check_cplx(i, result_o[i], impulse_bin);
                end

                fill_random();
                run_frame(8);

                for (int f = 0; f < RAND_FRAMES; f++) begin
                        fill_random();
                        run_frame(0);
                end

                // Control writes that must not start a transform
                bus_write(ADDR_CTRL, 32'h0000_0002);
                repeat (3) begin
                        check_flag("busy_o after start bit clear", busy_o, 1'b0);
                        @(negedge clk);
                end
                bus_cycle(1'b1, 1'b0, ADDR_CTRL, 32'h0000_0001);
                repeat (3) begin
                        check_flag("busy_o after read strobe", busy_o, 1'b0);
                        @(negedge clk);
                end
                check_count("done_o pulses at end", done_count, starts);

                $display("%0d checks, %0d errors", checks, errors);
                if (errors == 0)
                        $display("STATUS: PASS");
                else
                        $display("STATUS: FAIL");
                $finish;
        end

        initial begin
                #(WATCHDOG_NS);
                $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
                $display("STATUS: FAIL");
                $finish;
        end

endmodule

/* compile.f */
+incdir+verilog
verilog/bus_pkg.sv
verilog/fft_pkg.sv
verilog/sample_ram.sv
verilog/fft_butterfly.sv
verilog/fft_control.sv
verilog/fft_top.sv
sim/tb_fft_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the FFT testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -f compile.f --top-module tb_fft_top -o tb_fft_top || exit 1

out=$(./obj_dir/tb_fft_top)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx 'STATUS: PASS' && echo "Simulation passed" || {
        echo "Simulation failed"
        exit 1
}
